// ==== snappy_pkg.sv ====
/*
 * shared types and default sizes for the byte-serial snappy decompressor
 * imported by every RTL block that needs a byte, a tag kind or a size
 */
`default_nettype none

package snappy_pkg;

	typedef logic [7:0] byte_t;

	// low two bits of every tag byte
	typedef enum logic [1:0] {
		TAG_LITERAL = 2'b00,
		TAG_COPY1   = 2'b01, // 3-bit high offset in the tag, one offset byte
		TAG_COPY2   = 2'b10, // two offset bytes, low first
		TAG_COPY4   = 2'b11  // not supported
	} tag_kind_e;

	typedef enum logic [2:0] {
		PS_IDLE,
		PS_TAG,
		PS_LITERAL,
		PS_OFFSET_LO,
		PS_OFFSET_HI,
		PS_COPY_WAIT,
		PS_ERROR
	} parse_state_e;

	// history depth, must stay a power of two
	localparam int DEF_WINDOW_BYTES = 1024;

	localparam int DEF_COMP_LEN_W = 16; // compressed length field

	// literal or copy length, 1 to 64
	localparam int DEF_COPY_LEN_W = 7;

endpackage

`default_nettype wire

// ==== copy_cmd_if.sv ====
/*
 * copy command channel from the token parser to the copy engine
 * the parser strobes cmd_valid for one cycle, the engine answers with busy
 */
`timescale 1ns/1ps
`default_nettype none

interface copy_cmd_if
	import snappy_pkg::*;
#(
	parameter int WINDOW_BYTES = DEF_WINDOW_BYTES,
	localparam int OFF_W = $clog2(WINDOW_BYTES) + 1
);
	logic cmd_valid;
	logic [OFF_W-1:0] cmd_offset; // distance back from the write pointer
	logic [DEF_COPY_LEN_W-1:0] cmd_length;
	logic busy; // high while reads are being issued

	modport parser (output cmd_valid, output cmd_offset, output cmd_length, input busy);
	modport engine (input cmd_valid, input cmd_offset, input cmd_length, output busy);

endinterface

`default_nettype wire

// ==== token_parser.sv ====
/*
 * parses the compressed byte stream one tag at a time
 * literal bytes go straight to the history window, copies become commands
 * for the copy engine; unsupported tags or offsets stop the stream with an error
 */
`timescale 1ns/1ps
`default_nettype none

module token_parser
	import snappy_pkg::*;
#(
	parameter int WINDOW_BYTES = DEF_WINDOW_BYTES,
	parameter int COMP_LEN_W = DEF_COMP_LEN_W,
	localparam int OFF_W = $clog2(WINDOW_BYTES) + 1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_i,
	input  logic [COMP_LEN_W-1:0] comp_len_i,
	input  logic                  in_valid_i,
	input  byte_t                 in_byte_i,
	output logic                  in_ready_o,
	output logic                  done_o,
	output logic                  error_o,
	output logic                  lit_valid_o,
	output byte_t                 lit_byte_o,
	copy_cmd_if.parser            cmd
);

	parse_state_e state;
	logic [COMP_LEN_W-1:0] remain; // input bytes still to come
	logic [DEF_COPY_LEN_W-1:0] lit_cnt;
	logic [DEF_COPY_LEN_W-1:0] cp_len;
	logic [2:0] cp_hi; // offset bits 10:8 of a COPY1
	tag_kind_e cp_kind;
	byte_t off_lo;
	tag_kind_e tag;
	logic [15:0] full_off;
	logic off_bad;
	logic accept;

	assign tag = tag_kind_e'(in_byte_i[1:0]);
	assign accept = in_valid_i && in_ready_o;

	// offset as it stands once the last offset byte is on the input
	always_comb begin
		if (state == PS_OFFSET_HI) begin
			full_off = {in_byte_i, off_lo};
		end else begin
			full_off = {5'd0, cp_hi, in_byte_i};
		end
	end

	assign off_bad = (full_off == 16'd0) || ({16'd0, full_off} > WINDOW_BYTES);

	always_comb begin
		case (state)
			PS_TAG, PS_LITERAL, PS_OFFSET_LO, PS_OFFSET_HI:
				in_ready_o = !cmd.busy && (remain != '0);
			default:
				in_ready_o = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= PS_IDLE;
			remain <= '0;
			lit_cnt <= '0;
			error_o <= 1'b0;
			done_o <= 1'b0;
			lit_valid_o <= 1'b0;
			cmd.cmd_valid <= 1'b0;
		end else begin
			done_o <= 1'b0;
			lit_valid_o <= 1'b0;
			cmd.cmd_valid <= 1'b0;
			if (accept)
				remain <= remain - 1'b1;
			case (state)
				PS_IDLE: begin
					if (start_i) begin
						remain <= comp_len_i;
						error_o <= 1'b0;
						state <= PS_TAG;
					end
				end
				PS_TAG: begin
					if (remain == '0) begin
						// wait for the last literal to leave before done
						if (!lit_valid_o && !cmd.busy) begin
							done_o <= 1'b1;
							state <= PS_IDLE;
						end
					end else if (accept) begin
						case (tag)
							TAG_LITERAL: begin
								if (in_byte_i[7:2] >= 6'd60) begin
									state <= PS_ERROR; // long literal
								end else begin
									lit_cnt <= DEF_COPY_LEN_W'(in_byte_i[7:2]) + DEF_COPY_LEN_W'(1);
									state <= PS_LITERAL;
								end
							end
							TAG_COPY1, TAG_COPY2: state <= PS_OFFSET_LO;
							default: state <= PS_ERROR;
						endcase
					end
				end
				PS_LITERAL: begin
					if (accept) begin
						lit_valid_o <= 1'b1;
						lit_cnt <= lit_cnt - 1'b1;
						if (lit_cnt == DEF_COPY_LEN_W'(1))
							state <= PS_TAG;
					end else if (remain == '0) begin
						state <= PS_ERROR; // stream ends inside a literal
					end
				end
				PS_OFFSET_LO, PS_OFFSET_HI: begin
					if (accept) begin
						if (state == PS_OFFSET_LO && cp_kind == TAG_COPY2) begin
							state <= PS_OFFSET_HI;
						end else if (off_bad) begin
							state <= PS_ERROR;
						end else begin
							cmd.cmd_valid <= 1'b1;
							state <= PS_COPY_WAIT;
						end
					end else if (remain == '0) begin
						state <= PS_ERROR;
					end
				end
				PS_COPY_WAIT: begin
					// busy only rises the cycle after the strobe
					if (!cmd.busy && !cmd.cmd_valid)
						state <= PS_TAG;
				end
				default: begin
					error_o <= 1'b1;
					state <= PS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			lit_byte_o <= in_byte_i;
			if (state == PS_TAG) begin
				cp_kind <= tag;
				cp_hi <= in_byte_i[7:5];
				if (tag == TAG_COPY1) begin
					cp_len <= DEF_COPY_LEN_W'(in_byte_i[4:2]) + DEF_COPY_LEN_W'(4);
				end else begin
					cp_len <= DEF_COPY_LEN_W'(in_byte_i[7:2]) + DEF_COPY_LEN_W'(1);
				end
			end
			if (state == PS_OFFSET_LO)
				off_lo <= in_byte_i;
			cmd.cmd_offset <= OFF_W'(full_off);
			cmd.cmd_length <= cp_len;
		end
	end

endmodule

`default_nettype wire

// ==== copy_engine.sv ====
/*
 * turns one copy command into a run of history reads, one per cycle
 * the offset is held for the whole run since the window pointer moves with it
 */
`timescale 1ns/1ps
`default_nettype none

module copy_engine
	import snappy_pkg::*;
#(
	parameter int WINDOW_BYTES = DEF_WINDOW_BYTES,
	localparam int OFF_W = $clog2(WINDOW_BYTES) + 1
) (
	input  logic             clk,
	input  logic             rst_n,
	copy_cmd_if.engine       cmd,
	output logic             rd_valid_o,
	output logic [OFF_W-1:0] rd_offset_o
);

	logic [DEF_COPY_LEN_W-1:0] remain; // reads left including the current one

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid_o <= 1'b0;
			remain <= '0;
		end else if (cmd.cmd_valid) begin
			rd_valid_o <= 1'b1;
			remain <= cmd.cmd_length;
		end else if (rd_valid_o) begin
			remain <= remain - 1'b1;
			if (remain == DEF_COPY_LEN_W'(1))
				rd_valid_o <= 1'b0; // last read goes out this cycle
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.cmd_valid)
			rd_offset_o <= cmd.cmd_offset;
	end

	// busy covers exactly the cycles that carry a read
	assign cmd.busy = rd_valid_o;

endmodule

`default_nettype wire

// ==== history_window.sv ====
/*
 * sliding history of the decompressed output
 * every produced byte lands in the output register and is written back into
 * the memory one cycle later; reads address backwards from the next byte slot
 */
`timescale 1ns/1ps
`default_nettype none

module history_window
	import snappy_pkg::*;
#(
	parameter int WINDOW_BYTES = DEF_WINDOW_BYTES,
	localparam int PTR_W = $clog2(WINDOW_BYTES),
	localparam int OFF_W = PTR_W + 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             lit_valid_i,
	input  byte_t            lit_byte_i,
	input  logic             rd_valid_i,
	input  logic [OFF_W-1:0] rd_offset_i,
	output logic             out_valid_o,
	output byte_t            out_byte_o
);

	byte_t mem [WINDOW_BYTES];
	logic [PTR_W-1:0] wr_ptr; // slot of the byte held in the output register
	logic [PTR_W-1:0] rd_pos; // slot the byte being read will occupy
	logic [PTR_W-1:0] rd_addr;
	logic fwd;

	/*
	 * while the output register holds a byte it has not reached memory yet,
	 * so the new byte sits one slot further; an offset of the full window
	 * wraps onto the oldest slot
	 */
	assign rd_pos = wr_ptr + PTR_W'(out_valid_o);
	assign rd_addr = rd_pos - rd_offset_i[PTR_W-1:0];

	// offset 1 in a run asks for the byte written on this very edge
	assign fwd = out_valid_o && (rd_addr == wr_ptr);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_o <= 1'b0;
			wr_ptr <= '0;
		end else begin
			out_valid_o <= lit_valid_i || rd_valid_i;
			if (out_valid_o)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (out_valid_o)
			mem[wr_ptr] <= out_byte_o; // write back the previous output
		if (lit_valid_i) begin
			out_byte_o <= lit_byte_i;
		end else if (rd_valid_i) begin
			if (fwd) begin
				out_byte_o <= out_byte_o; // repeat the byte just produced
			end else begin
				out_byte_o <= mem[rd_addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== snappy_decompressor.sv ====
/*
 * top level of the byte-serial snappy decompressor
 * bytes enter with a valid/ready handshake after a start strobe with the
 * compressed length; decoded bytes leave as single-cycle strobes
 */
`timescale 1ns/1ps
`default_nettype none

module snappy_decompressor
	import snappy_pkg::*;
#(
	parameter int WINDOW_BYTES = DEF_WINDOW_BYTES,
	parameter int COMP_LEN_W = DEF_COMP_LEN_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start_i,
	input  logic [COMP_LEN_W-1:0] comp_len_i,
	input  logic                  in_valid_i,
	input  byte_t                 in_byte_i,
	output logic                  in_ready_o,
	output logic                  out_valid_o,
	output byte_t                 out_byte_o,
	output logic                  done_o,
	output logic                  error_o
);

	localparam int OFF_W = $clog2(WINDOW_BYTES) + 1;

	logic lit_valid;
	byte_t lit_byte;
	logic rd_valid;
	logic [OFF_W-1:0] rd_offset;

	copy_cmd_if #(.WINDOW_BYTES(WINDOW_BYTES)) cmd_bus ();

	token_parser #(
		.WINDOW_BYTES(WINDOW_BYTES),
		.COMP_LEN_W  (COMP_LEN_W)
	) u_parser (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_i    (start_i),
		.comp_len_i (comp_len_i),
		.in_valid_i (in_valid_i),
		.in_byte_i  (in_byte_i),
		.in_ready_o (in_ready_o),
		.done_o     (done_o),
		.error_o    (error_o),
		.lit_valid_o(lit_valid),
		.lit_byte_o (lit_byte),
		.cmd        (cmd_bus.parser)
	);

	copy_engine #(.WINDOW_BYTES(WINDOW_BYTES)) u_engine (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd_bus.engine),
		.rd_valid_o (rd_valid),
		.rd_offset_o(rd_offset)
	);

	history_window #(.WINDOW_BYTES(WINDOW_BYTES)) u_window (
		.clk        (clk),
		.rst_n      (rst_n),
		.lit_valid_i(lit_valid),
		.lit_byte_i (lit_byte),
		.rd_valid_i (rd_valid),
		.rd_offset_i(rd_offset),
		.out_valid_o(out_valid_o),
		.out_byte_o (out_byte_o)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
/*
 * free-running testbench clock
 * starts low at time zero and toggles every half period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 10
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
/*
 * watches the decompressor outputs and compares every output strobe in order
 * against the byte queue handed over by the testbench top for each stream
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
	import snappy_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  start_i,
	input logic  in_ready_i,
	input logic  out_valid_i,
	input byte_t out_byte_i,
	input logic  done_i,
	input logic  error_i
);

	byte_t exp_q[$]; // bytes still to come for the current stream
	string test_name = "none";
	bit exp_err = 1'b0;
	bit stream_over = 1'b1;
	bit err_seen = 1'b0; // error level on the previous edge
	bit clear_due = 1'b0;
	int got = 0;
	int errors = 0;
	int bytes_checked = 0;
	int streams_checked = 0;

	task automatic expect_stream(input string name, input byte_t q[$], input bit err);
		test_name = name;
		exp_q = q;
		exp_err = err;
		got = 0;
		stream_over = 1'b0;
	endtask

	task automatic check_reset();
		if ({in_ready_i, out_valid_i, done_i, error_i} !== 4'b0000) begin
			errors++;
			$display("outputs not all low after reset: ready %b valid %b done %b error %b",
				in_ready_i, out_valid_i, done_i, error_i);
		end
	endtask

	// anything left in the queue never came out
	task automatic end_stream(input string why);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%s: %0d expected bytes missing when the %s came", test_name,
				exp_q.size(), why);
		end
		streams_checked++;
		stream_over = 1'b1;
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (out_valid_i) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: extra output byte 0x%02h", test_name, out_byte_i);
				end else begin
					if (out_byte_i !== exp_q[0]) begin
						errors++;
						$display("[ERROR] %s byte %0d: expected 0x%02h, actual 0x%02h",
							test_name, got, exp_q[0], out_byte_i);
					end
					void'(exp_q.pop_front());
					got++;
					bytes_checked++;
				end
			end
			if (done_i && stream_over) begin
				errors++;
				$display("%s: second done pulse after the stream had ended", test_name);
			end else if (done_i) begin
				if (exp_err) begin
					errors++;
					$display("%s: done pulse where the error flag should have risen", test_name);
				end
				end_stream("done pulse");
			end
			if (error_i && !err_seen) begin
				if (!exp_err) begin
					errors++;
					$display("[ERROR] %s error flag: expected 0, actual 1", test_name);
				end
				if (!stream_over)
					end_stream("error flag");
			end
			if (clear_due && error_i) begin
				errors++;
				$display("%s: error flag still high after start", test_name);
			end
			clear_due = start_i; // start clears the flag on this same edge
			err_seen = error_i;
		end
	end

endmodule

`default_nettype wire

// ==== tb_snappy_decompressor.sv ====
/*
 * testbench top for the snappy decompressor
 * a small encoder builds token streams, decode_ref predicts the output and
 * tb_checker compares it with what the DUT produces
 */
`timescale 1ns/1ps
`default_nettype none

module tb_snappy_decompressor
	import snappy_pkg::*;
();

	localparam int SEED = 83;
	localparam int N_RANDOM = 20;
	localparam int CYC_PER_BYTE = 20; // watchdog budget per input byte
	localparam int CYC_PER_TOKEN = 64;

	logic clk, rst_n, start_i, in_valid_i;
	logic [DEF_COMP_LEN_W-1:0] comp_len_i;
	byte_t in_byte_i, out_byte_o;
	logic in_ready_o, out_valid_o, done_o, error_o;

	byte_t all_bytes[$]; // every stream back to back
	int stream_len[$];
	string stream_name[$];
	byte_t cur[$]; // stream under construction
	int produced = 0; // decoded length of cur so far
	int n_tokens = 0;
	int budget = 0;
	bit budget_set = 1'b0;

	tb_clock_gen clk_gen (.clk_o(clk));

	snappy_decompressor #(
		.WINDOW_BYTES(DEF_WINDOW_BYTES),
		.COMP_LEN_W  (DEF_COMP_LEN_W)
	) UUT (.*);

	tb_checker chk (
		.clk(clk), .rst_n(rst_n), .start_i(start_i), .in_ready_i(in_ready_o),
		.out_valid_i(out_valid_o), .out_byte_i(out_byte_o), .done_i(done_o), .error_i(error_o)
	);

	// expected output of one stream, returns 1 where decoding must stop with an error
	function automatic bit decode_ref(input byte_t s[$], output byte_t q[$]);
		int i;
		int len;
		int off;
		byte_t tag;
		q = {};
		i = 0;
		while (i < s.size()) begin
			tag = s[i];
			case (tag_kind_e'(tag[1:0]))
				TAG_LITERAL: begin
					len = int'(tag[7:2]) + 1;
					if (tag[7:2] >= 6'd60 || i + len >= s.size())
						return 1'b1;
					for (int k = 1; k <= len; k++)
						q.push_back(s[i + k]);
					i += len + 1;
				end
				TAG_COPY1, TAG_COPY2: begin
					if (tag[1:0] == 2'b01) begin
						if (i + 1 >= s.size())
							return 1'b1;
						len = int'(tag[4:2]) + 4;
						off = int'(tag[7:5]) * 256 + int'(s[i + 1]);
						i += 2;
					end else begin
						if (i + 2 >= s.size())
							return 1'b1;
						len = int'(tag[7:2]) + 1;
						off = int'(s[i + 1]) + 256 * int'(s[i + 2]);
						i += 3;
					end
					if (off == 0 || off > DEF_WINDOW_BYTES || off > q.size())
						return 1'b1;
					repeat (len) q.push_back(q[q.size() - off]); // byte by byte, so overlap repeats
				end
				default: return 1'b1; // four-byte offsets are not decoded
			endcase
		end
		return 1'b0;
	endfunction

	task automatic put_literal(input int len);
		cur.push_back(byte_t'((len - 1) << 2));
		repeat (len) cur.push_back(byte_t'($urandom));
		produced += len;
		n_tokens++;
	endtask

	task automatic put_copy1(input int len, input int off); // len 4 to 11
		cur.push_back(byte_t'(((off >> 8) << 5) | ((len - 4) << 2) | 1));
		cur.push_back(byte_t'(off));
		produced += len;
		n_tokens++;
	endtask

	task automatic put_copy2(input int len, input int off);
		cur.push_back(byte_t'(((len - 1) << 2) | 2));
		cur.push_back(byte_t'(off));
		cur.push_back(byte_t'(off >> 8));
		produced += len;
		n_tokens++;
	endtask

	task automatic put_raw(input byte_t b);
		cur.push_back(b);
		n_tokens++;
	endtask

	task automatic end_stream(input string name);
		foreach (cur[k]) all_bytes.push_back(cur[k]);
		stream_len.push_back(cur.size());
		stream_name.push_back(name);
		budget += CYC_PER_BYTE * cur.size() + CYC_PER_TOKEN * n_tokens;
		cur.delete();
		produced = 0;
		n_tokens = 0;
	endtask

	task automatic build_random(input int idx);
		int off;
		put_literal(1 + $urandom_range(59));
		repeat (10) begin
			off = 1 + $urandom_range(produced - 1); // stays inside this stream's output
			case ($urandom_range(2))
				0: put_literal(1 + $urandom_range(59));
				1: put_copy1(4 + $urandom_range(7), off);
				default: put_copy2(1 + $urandom_range(63), off);
			endcase
		end
		end_stream($sformatf("random_%0d", idx));
	endtask

	task automatic run_stream(input byte_t s[$]);
		int idx;
		idx = 0;
		start_i <= 1'b1;
		comp_len_i <= DEF_COMP_LEN_W'(s.size());
		@(posedge clk);
		start_i <= 1'b0;
		@(posedge clk); // old error flag is gone by now
		while (idx < s.size() && !error_o) begin
			in_valid_i <= ($urandom_range(3) != 0); // gap about one cycle in four
			in_byte_i <= s[idx];
			@(posedge clk);
			if (in_valid_i && in_ready_o)
				idx++;
		end
		in_valid_i <= 1'b0;
		while (!chk.stream_over)
			@(posedge clk);
	endtask

	initial begin
		byte_t s[$];
		byte_t exp_q[$];
		bit exp_err;
		int base;
		void'($urandom(SEED));
		rst_n = 1'b0;
		start_i = 1'b0;
		comp_len_i = '0;
		in_valid_i = 1'b0;
		in_byte_i = '0;

		put_literal(1);
		put_literal(17);
		put_literal(60);
		end_stream("literals");
		put_literal(40);
		put_copy1(8, 40); // whole history so far
		put_copy2(30, 48);
		put_copy2(64, 78);
		put_literal(60);
		put_literal(60);
		put_copy1(6, 262); // offset bits 10:8 in the tag
		end_stream("far_copies");
		put_literal(1);
		put_copy2(40, 1);
		put_literal(3);
		put_copy2(20, 3);
		put_copy1(9, 2);
		end_stream("overlap");
		for (int r = 0; r < N_RANDOM; r++)
			build_random(r);
		put_literal(5);
		put_raw(8'h07); // four-byte offset copy
		put_literal(3);
		end_stream("copy4_tag");
		put_literal(4);
		put_raw(8'hf4); // literal length field 61
		put_literal(2);
		end_stream("long_literal");
		put_literal(6);
		end_stream("after_error");
		budget_set = 1'b1;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		chk.check_reset();
		base = 0;
		foreach (stream_len[i]) begin
			s.delete();
			for (int k = 0; k < stream_len[i]; k++)
				s.push_back(all_bytes[base + k]);
			base += stream_len[i];
			exp_err = decode_ref(s, exp_q);
			chk.expect_stream(stream_name[i], exp_q, exp_err);
			run_stream(s);
		end
		$display("streams %0d of %0d, bytes checked %0d, errors %0d", chk.streams_checked,
			stream_len.size(), chk.bytes_checked, chk.errors);
		if (chk.errors == 0 && chk.streams_checked == stream_len.size())
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		wait (budget_set);
		repeat (budget + 16) @(posedge clk);
		$display("timeout after %0d cycles, stream %s got neither done pulse nor error flag",
			budget, chk.test_name);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
snappy_pkg.sv
copy_cmd_if.sv
token_parser.sv
copy_engine.sv
history_window.sv
snappy_decompressor.sv
tb_clock_gen.sv
tb_checker.sv
tb_snappy_decompressor.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_snappy_decompressor
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -Wno-fatal --Mdir $(OBJ_DIR) --top-module $(TOP)
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the exit status follows the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
